// File: rtl/dbus_pkg.sv
package dbus_pkg;

    localparam int NCORES    = 4;
    localparam int XLEN      = 32;
    localparam int STRB_W    = XLEN / 8;
    localparam int MEM_WORDS = 256;
    localparam int CORE_W    = $clog2(NCORES);
    localparam int WADDR_W   = $clog2(MEM_WORDS);
    localparam int OFFS_W    = $clog2(STRB_W);

    localparam logic [1:0] ST_IDLE   = 2'd0;
    localparam logic [1:0] ST_CHECK  = 2'd1; // reservation check
    localparam logic [1:0] ST_ACCESS = 2'd2;

    localparam logic [1:0] RSV_SET = 2'd0; // lr
    localparam logic [1:0] RSV_SC  = 2'd1;
    localparam logic [1:0] RSV_CLR = 2'd2; // plain store

    typedef logic [CORE_W-1:0]  core_idx_t;
    typedef logic [WADDR_W-1:0] word_addr_t;

    typedef struct packed {
        logic              valid;
        logic              we;
        logic              lr;
        logic              sc;    // sc is a write with this flag set
        logic [XLEN-1:0]   addr;
        logic [XLEN-1:0]   wdata;
        logic [STRB_W-1:0] wstrb;
    } core_req_t;

    typedef struct packed {
        logic              re;
        logic              we;
        word_addr_t        addr;
        logic [XLEN-1:0]   wdata;
        logic [STRB_W-1:0] wstrb;
    } mem_port_t;

    typedef struct packed {
        logic      valid;
        core_idx_t core;
    } lane_pick_t;

    typedef struct packed {
        logic            valid;
        logic [1:0]      kind;
        core_idx_t       core;
        logic [XLEN-1:0] addr;
    } rsv_op_t;

    typedef union packed {
        logic [XLEN-1:0] load;
        struct packed {
            logic [XLEN-2:0] pad;
            logic            fail; // 0 on success
        } sc;
    } rsp_word_u;

endpackage

// File: rtl/dbus_req_slots.sv
`timescale 1ns/1ps

module dbus_req_slots (
    input  logic                                       clk_i,
    input  logic                                       rst_i,
    input  dbus_pkg::core_req_t [dbus_pkg::NCORES-1:0] req_i,
    input  logic [dbus_pkg::NCORES-1:0]                release_i,
    output logic [dbus_pkg::NCORES-1:0]                pend_o,
    output dbus_pkg::core_req_t [dbus_pkg::NCORES-1:0] slot_o,
    output logic [dbus_pkg::NCORES-1:0]                busy_o
);
    import dbus_pkg::*;

    logic [NCORES-1:0]      held_q;
    logic [NCORES-1:0]      fly1_q; // lane in access
    logic [NCORES-1:0]      fly2_q; // read data cycle
    logic [NCORES-1:0]      take;
    core_req_t [NCORES-1:0] data_q;

    assign busy_o = held_q | fly1_q | fly2_q;
    assign pend_o = held_q;

    always_comb begin
        for (int k = 0; k < NCORES; k++) begin
            take[k]         = req_i[k].valid && !busy_o[k];
            slot_o[k]       = data_q[k];
            slot_o[k].valid = held_q[k];
        end
    end

    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            held_q <= '0;
            fly1_q <= '0;
            fly2_q <= '0;
        end else begin
            held_q <= (held_q & ~release_i) | take;
            fly1_q <= release_i;
            fly2_q <= fly1_q;
        end
    end

    always_ff @(posedge clk_i) begin
        for (int k = 0; k < NCORES; k++) begin
            if (take[k]) begin
                data_q[k] <= req_i[k];
            end
        end
    end

endmodule

// File: rtl/dbus_rr_arbiter.sv
`timescale 1ns/1ps

module dbus_rr_arbiter (
    input  dbus_pkg::core_idx_t        ptr_i,
    input  logic [dbus_pkg::NCORES-1:0] pend_i,
    input  logic [1:0]                 lane_free_i,
    input  dbus_pkg::lane_pick_t [1:0] owner_i,
    output dbus_pkg::lane_pick_t       pick_a_o,
    output dbus_pkg::lane_pick_t       pick_b_o
);
    import dbus_pkg::*;

    logic [NCORES-1:0] elig;
    lane_pick_t        first;
    lane_pick_t        second;

    always_comb begin
        for (int k = 0; k < NCORES; k++) begin
            elig[k] = pend_i[k];
            for (int l = 0; l < 2; l++) begin
                if (owner_i[l].valid && owner_i[l].core == core_idx_t'(k)) begin
                    elig[k] = 1'b0; // already held by a busy lane
                end
            end
        end
    end

    always_comb begin : scan
        core_idx_t idx;
        first  = '0;
        second = '0;
        for (int i = 0; i < NCORES; i++) begin
            idx = core_idx_t'((int'(ptr_i) + i) % NCORES);
            if (elig[idx]) begin
                if (!first.valid) begin
                    first.valid = 1'b1;
                    first.core  = idx;
                end else if (!second.valid) begin
                    second.valid = 1'b1;
                    second.core  = idx;
                end
            end
        end
    end

    always_comb begin
        pick_a_o = '0;
        pick_b_o = '0;
        if (lane_free_i[0]) begin
            pick_a_o = first;
            if (lane_free_i[1]) begin
                pick_b_o = second;
            end
        end else if (lane_free_i[1]) begin
            pick_b_o = first; // lane a busy, b takes the head
        end
    end

endmodule

// File: rtl/dbus_lane_ctrl.sv
`timescale 1ns/1ps

module dbus_lane_ctrl (
    input  logic                                       clk_i,
    input  logic                                       rst_i,
    input  dbus_pkg::lane_pick_t                       pick_a_i,
    input  dbus_pkg::lane_pick_t                       pick_b_i,
    input  dbus_pkg::core_req_t [dbus_pkg::NCORES-1:0] slot_i,
    input  logic [1:0]                                 sc_ok_i,
    input  logic [1:0][dbus_pkg::XLEN-1:0]             rdata_i,
    output dbus_pkg::core_idx_t                        ptr_o,
    output dbus_pkg::lane_pick_t [1:0]                 owner_o,
    output logic [1:0]                                 lane_free_o,
    output logic [dbus_pkg::NCORES-1:0]                release_o,
    output dbus_pkg::rsv_op_t [1:0]                    rsv_op_o,
    output dbus_pkg::mem_port_t [1:0]                  port_o,
    output logic [dbus_pkg::NCORES-1:0]                rsp_valid_o,
    output dbus_pkg::rsp_word_u [dbus_pkg::NCORES-1:0] rsp_data_o
);
    import dbus_pkg::*;

    lane_pick_t [1:0]       pick;
    logic [1:0][1:0]        state_q;
    logic [1:0][1:0]        state_d;
    core_idx_t [1:0]        core_q;
    core_req_t [1:0]        req_q;
    lane_pick_t [1:0]       ret_q;
    logic [1:0]             ret_we_q;
    logic [1:0]             ret_sc_q;
    logic [1:0]             ret_fail_q;
    core_idx_t              ptr_q;
    core_idx_t              ptr_d;
    logic [NCORES-1:0]      rsp_vd;
    rsp_word_u [NCORES-1:0] rsp_d;

    function automatic core_idx_t next_core(core_idx_t c);
        return (c == core_idx_t'(NCORES - 1)) ? '0 : c + 1'b1;
    endfunction

    assign pick[0] = pick_a_i;
    assign pick[1] = pick_b_i;
    assign ptr_o   = ptr_q;

    always_comb begin
        release_o = '0;
        ptr_d     = ptr_q;
        for (int l = 0; l < 2; l++) begin
            state_d[l] = state_q[l];
            case (state_q[l])
                ST_IDLE: begin
                    if (pick[l].valid) begin
                        if (slot_i[pick[l].core].we || slot_i[pick[l].core].lr) begin
                            state_d[l] = ST_CHECK;
                        end else begin
                            state_d[l]              = ST_ACCESS; // plain load
                            release_o[pick[l].core] = 1'b1;
                        end
                    end
                end
                ST_CHECK: begin
                    state_d[l]           = ST_ACCESS;
                    release_o[core_q[l]] = 1'b1;
                end
                ST_ACCESS: begin
                    state_d[l] = ST_IDLE;
                    ptr_d      = next_core(core_q[l]); // lane b overrides when both finish
                end
                default: state_d[l] = ST_IDLE;
            endcase

            owner_o[l].valid  = (state_q[l] != ST_IDLE);
            owner_o[l].core   = core_q[l];
            lane_free_o[l]    = (state_q[l] == ST_IDLE);
            rsv_op_o[l].valid = (state_q[l] == ST_CHECK);
            rsv_op_o[l].kind  = req_q[l].lr ? RSV_SET : (req_q[l].sc ? RSV_SC : RSV_CLR);
            rsv_op_o[l].core  = core_q[l];
            rsv_op_o[l].addr  = req_q[l].addr;
            port_o[l].re      = (state_q[l] == ST_ACCESS) && !req_q[l].we;
            port_o[l].we      = (state_q[l] == ST_ACCESS) && req_q[l].we
                                && (!req_q[l].sc || sc_ok_i[l]); // failed sc never writes
            port_o[l].addr    = req_q[l].addr[OFFS_W +: WADDR_W];
            port_o[l].wdata   = req_q[l].wdata;
            port_o[l].wstrb   = req_q[l].wstrb;
        end
    end

    always_comb begin
        for (int k = 0; k < NCORES; k++) begin
            rsp_vd[k] = 1'b0;
            rsp_d[k]  = '0;
            for (int l = 0; l < 2; l++) begin
                if (ret_q[l].valid && ret_q[l].core == core_idx_t'(k)) begin
                    rsp_vd[k] = 1'b1;
                    if (ret_sc_q[l]) begin
                        rsp_d[k].sc.fail = ret_fail_q[l];
                    end else if (!ret_we_q[l]) begin
                        rsp_d[k].load = rdata_i[l];
                    end
                end
            end
        end
    end

    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            state_q     <= {ST_IDLE, ST_IDLE};
            ptr_q       <= '0;
            ret_q       <= '0;
            rsp_valid_o <= '0;
        end else begin
            state_q     <= state_d;
            ptr_q       <= ptr_d;
            rsp_valid_o <= rsp_vd;
            for (int l = 0; l < 2; l++) begin
                ret_q[l].valid <= (state_q[l] == ST_ACCESS);
                ret_q[l].core  <= core_q[l];
            end
        end
    end

    always_ff @(posedge clk_i) begin
        for (int l = 0; l < 2; l++) begin
            if (state_q[l] == ST_IDLE && pick[l].valid) begin
                core_q[l] <= pick[l].core;
                req_q[l]  <= slot_i[pick[l].core];
            end
            ret_we_q[l]   <= req_q[l].we;
            ret_sc_q[l]   <= req_q[l].sc;
            ret_fail_q[l] <= !sc_ok_i[l];
        end
        rsp_data_o <= rsp_d;
    end

endmodule

// File: rtl/dbus_reservation.sv
`timescale 1ns/1ps

module dbus_reservation (
    input  logic              clk_i,
    input  logic              rst_i,
    input  dbus_pkg::rsv_op_t op_a_i,
    input  dbus_pkg::rsv_op_t op_b_i,
    output logic [1:0]        sc_ok_o
);
    import dbus_pkg::*;

    rsv_op_t [1:0]                        op;
    logic [NCORES-1:0]                    rv_q;
    logic [NCORES-1:0]                    rv_d;
    logic [NCORES-1:0][XLEN-OFFS_W-1:0]   ra_q; // reserved word address
    logic [NCORES-1:0][XLEN-OFFS_W-1:0]   ra_d;
    logic [1:0]                           ok_d;

    assign op[0] = op_a_i;
    assign op[1] = op_b_i;

    // lane b runs second so it sees lane a's update
    always_comb begin : apply
        logic [XLEN-OFFS_W-1:0] tag;
        rv_d = rv_q;
        ra_d = ra_q;
        ok_d = '0;
        for (int l = 0; l < 2; l++) begin
            tag = op[l].addr[XLEN-1:OFFS_W];
            if (op[l].valid) begin
                case (op[l].kind)
                    RSV_SET: begin
                        rv_d[op[l].core] = 1'b1;
                        ra_d[op[l].core] = tag;
                    end
                    RSV_SC:  ok_d[l] = rv_d[op[l].core] && (ra_d[op[l].core] == tag);
                    default: ;
                endcase
                if (op[l].kind == RSV_CLR || ok_d[l]) begin
                    for (int k = 0; k < NCORES; k++) begin
                        if (ra_d[k] == tag) begin
                            rv_d[k] = 1'b0; // drop every match
                        end
                    end
                end
            end
        end
    end

    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            rv_q    <= '0;
            sc_ok_o <= '0;
        end else begin
            rv_q    <= rv_d;
            sc_ok_o <= ok_d; // valid in the access cycle
        end
    end

    always_ff @(posedge clk_i) begin
        ra_q <= ra_d;
    end

endmodule

// File: rtl/dbus_dmem.sv
`timescale 1ns/1ps

module dbus_dmem (
    input  logic                    clk_i,
    input  dbus_pkg::mem_port_t     port_a_i,
    input  dbus_pkg::mem_port_t     port_b_i,
    output logic [dbus_pkg::XLEN-1:0] rdata_a_o,
    output logic [dbus_pkg::XLEN-1:0] rdata_b_o
);
    import dbus_pkg::*;

    logic [XLEN-1:0]       mem_q [MEM_WORDS];
    mem_port_t [1:0]       port;
    logic [1:0][XLEN-1:0]  rdata_q;

    assign port[0]   = port_a_i;
    assign port[1]   = port_b_i;
    assign rdata_a_o = rdata_q[0];
    assign rdata_b_o = rdata_q[1];

    // port b lands last on a same-word collision
    always_ff @(posedge clk_i) begin
        for (int p = 0; p < 2; p++) begin
            if (port[p].re) begin
                rdata_q[p] <= mem_q[port[p].addr]; // old word on read-during-write
            end
            if (port[p].we) begin
                for (int b = 0; b < STRB_W; b++) begin
                    if (port[p].wstrb[b]) begin
                        mem_q[port[p].addr][8*b +: 8] <= port[p].wdata[8*b +: 8];
                    end
                end
            end
        end
    end

endmodule

// File: rtl/dbus_top.sv
`timescale 1ns/1ps

module dbus_top (
    input  logic                                       clk_i,
    input  logic                                       rst_i,
    input  dbus_pkg::core_req_t [dbus_pkg::NCORES-1:0] req_i,
    output logic [dbus_pkg::NCORES-1:0]                busy_o,
    output logic [dbus_pkg::NCORES-1:0]                rsp_valid_o,
    output dbus_pkg::rsp_word_u [dbus_pkg::NCORES-1:0] rsp_data_o
);
    import dbus_pkg::*;

    logic [NCORES-1:0]    pend;
    core_req_t [NCORES-1:0] slot;
    logic [NCORES-1:0]    rel_pulse;
    core_idx_t            ptr;
    lane_pick_t [1:0]     owner;
    logic [1:0]           lane_free;
    lane_pick_t           pick_a;
    lane_pick_t           pick_b;
    rsv_op_t [1:0]        rsv_op;
    logic [1:0]           sc_ok;
    mem_port_t [1:0]      port;
    logic [1:0][XLEN-1:0] rdata;

    dbus_req_slots u_slots (
        .clk_i    (clk_i),
        .rst_i    (rst_i),
        .req_i    (req_i),
        .release_i(rel_pulse),
        .pend_o   (pend),
        .slot_o   (slot),
        .busy_o   (busy_o)
    );

    dbus_rr_arbiter u_arb (
        .ptr_i      (ptr),
        .pend_i     (pend),
        .lane_free_i(lane_free),
        .owner_i    (owner),
        .pick_a_o   (pick_a),
        .pick_b_o   (pick_b)
    );

    dbus_lane_ctrl u_ctrl (
        .clk_i      (clk_i),
        .rst_i      (rst_i),
        .pick_a_i   (pick_a),
        .pick_b_i   (pick_b),
        .slot_i     (slot),
        .sc_ok_i    (sc_ok),
        .rdata_i    (rdata),
        .ptr_o      (ptr),
        .owner_o    (owner),
        .lane_free_o(lane_free),
        .release_o  (rel_pulse),
        .rsv_op_o   (rsv_op),
        .port_o     (port),
        .rsp_valid_o(rsp_valid_o),
        .rsp_data_o (rsp_data_o)
    );

    dbus_reservation u_rsv (
        .clk_i  (clk_i),
        .rst_i  (rst_i),
        .op_a_i (rsv_op[0]),
        .op_b_i (rsv_op[1]),
        .sc_ok_o(sc_ok)
    );

    dbus_dmem u_dmem (
        .clk_i    (clk_i),
        .port_a_i (port[0]),
        .port_b_i (port[1]),
        .rdata_a_o(rdata[0]),
        .rdata_b_o(rdata[1])
    );

endmodule

// File: bench/dbus_checker.sv
`timescale 1ns/1ps

module dbus_checker (
    input  logic                                       clk_i,
    input  logic                                       rst_i,
    input  dbus_pkg::core_req_t [dbus_pkg::NCORES-1:0] req_i,
    input  logic [dbus_pkg::NCORES-1:0]                busy_i,
    input  logic [dbus_pkg::NCORES-1:0]                rsp_valid_i,
    input  dbus_pkg::rsp_word_u [dbus_pkg::NCORES-1:0] rsp_data_i
);
    import dbus_pkg::*;

    int                n_pass  = 0;
    int                n_fail  = 0;
    bit                started = 1'b0;
    logic [XLEN-1:0]   mem_m [MEM_WORDS]; // reference memory
    logic [NCORES-1:0] rsv_v   = '0;
    word_addr_t        rsv_a [NCORES];
    core_req_t         held_req [NCORES];
    logic [NCORES-1:0] held_v  = '0;
    string             tname [NCORES];
    logic [NCORES-1:0] exp_fail;

    task automatic note(input int k, input string nm, input bit fail);
        tname[k]    = nm;
        exp_fail[k] = fail; // expected sc status from the table
    endtask

    function automatic logic [XLEN-1:0] merge(input logic [XLEN-1:0] old, input core_req_t r);
        for (int b = 0; b < STRB_W; b++) begin
            if (r.wstrb[b]) begin
                old[8*b +: 8] = r.wdata[8*b +: 8];
            end
        end
        return old;
    endfunction

    task automatic check_rsp(input int k);
        core_req_t  r;
        word_addr_t w;
        rsp_word_u  e;
        logic       ok;
        r  = held_req[k];
        w  = r.addr[OFFS_W +: WADDR_W];
        e  = '0;
        ok = rsv_v[k] && (rsv_a[k] == w);
        if (r.sc) begin
            e.sc.fail = !ok;
        end else if (!r.we) begin
            e.load = mem_m[w];
        end
        if (r.lr) begin
            rsv_v[k] = 1'b1;
            rsv_a[k] = w;
        end
        if (r.we && (!r.sc || ok)) begin
            mem_m[w] = merge(mem_m[w], r);
            for (int c = 0; c < NCORES; c++) begin
                if (rsv_a[c] == w) begin
                    rsv_v[c] = 1'b0; // any write to the word drops its reservations
                end
            end
        end
        if (rsp_data_i[k].load !== e.load) begin
            $display("ERR %s expected %h actual %h", tname[k], e.load, rsp_data_i[k].load);
            n_fail++;
        end else if (r.sc && rsp_data_i[k].sc.fail !== exp_fail[k]) begin
            $display("ERR %s expected %0d actual %0d", tname[k], exp_fail[k],
                     rsp_data_i[k].sc.fail);
            n_fail++;
        end else begin
            $display("PASS %s", tname[k]);
            n_pass++;
        end
    endtask

    always @(posedge clk_i) begin
        if (!rst_i) begin
            if (!started) begin
                if (busy_i !== '0 || rsp_valid_i !== '0) begin
                    $display("busy or response went high before any request was posted");
                    n_fail++;
                    started = 1'b1;
                end else if (req_i[0].valid || req_i[1].valid || req_i[2].valid
                             || req_i[3].valid) begin
                    $display("PASS idle_after_reset");
                    n_pass++;
                    started = 1'b1;
                end
            end
            for (int k = 0; k < NCORES; k++) begin
                if (rsp_valid_i[k]) begin
                    if (!held_v[k]) begin
                        $display("core %0d got a response with no request outstanding", k);
                        n_fail++;
                    end else begin
                        check_rsp(k);
                        held_v[k] = 1'b0;
                    end
                end
                if (req_i[k].valid && !busy_i[k]) begin
                    held_req[k] = req_i[k]; // slot capture
                    held_v[k]   = 1'b1;
                end
            end
        end
    end

endmodule

// File: bench/tb_dbus.sv
`timescale 1ns/1ps

module tb_dbus;
    import dbus_pkg::*;

    localparam time PERIOD  = 100ns;
    localparam int  TIMEOUT = 40; // cycles per wait
    localparam int  K_LD    = 0;
    localparam int  K_ST    = 1;
    localparam int  K_LR    = 2;
    localparam int  K_SC    = 3;

    typedef struct packed {
        logic              same;     // issue in the cycle of the previous row
        logic              rnd;      // random wdata
        logic [1:0]        kind;
        core_idx_t         core;
        logic [XLEN-1:0]   addr;
        logic [XLEN-1:0]   wdata;
        logic [STRB_W-1:0] wstrb;
        logic              exp_fail; // expected sc status
    } row_t;

    logic                   clk;
    logic                   rst;
    core_req_t [NCORES-1:0] req;
    logic [NCORES-1:0]      busy;
    logic [NCORES-1:0]      rsp_valid;
    rsp_word_u [NCORES-1:0] rsp_data;
    row_t                   tab[$];
    string                  tname[$];
    int                     seed      = 84093;
    bit                     timed_out = 1'b0;

    dbus_top dut (
        .clk_i      (clk),
        .rst_i      (rst),
        .req_i      (req),
        .busy_o     (busy),
        .rsp_valid_o(rsp_valid),
        .rsp_data_o (rsp_data)
    );

    dbus_checker chk (
        .clk_i      (clk),
        .rst_i      (rst),
        .req_i      (req),
        .busy_i     (busy),
        .rsp_valid_i(rsp_valid),
        .rsp_data_i (rsp_data)
    );

    initial begin
        clk = 1'b0;
        forever #(PERIOD / 2) clk = ~clk;
    end

    task automatic add_row(input string nm, input bit same, input bit rnd, input int kind,
                           input int core, input logic [XLEN-1:0] addr,
                           input logic [XLEN-1:0] wdata, input int wstrb, input bit fail);
        row_t r;
        r.same     = same;
        r.rnd      = rnd;
        r.kind     = kind[1:0];
        r.core     = core_idx_t'(core);
        r.addr     = addr;
        r.wdata    = wdata;
        r.wstrb    = wstrb[STRB_W-1:0];
        r.exp_fail = fail;
        tab.push_back(r);
        tname.push_back(nm);
    endtask

    task automatic load_table();
        add_row("st_full",     0, 0, K_ST, 0, 'h10, 'h11223344, 'hf, 0);
        add_row("st_part",     0, 0, K_ST, 0, 'h10, 'haabbccdd, 'h5, 0);
        add_row("ld_merge",    0, 0, K_LD, 0, 'h10, 0, 0, 0);
        add_row("st_c0",       0, 1, K_ST, 0, 'h40, 0, 'hf, 0);
        add_row("st_c1",       1, 1, K_ST, 1, 'h44, 0, 'hf, 0);
        add_row("st_c2",       1, 1, K_ST, 2, 'h48, 0, 'hf, 0);
        add_row("st_c3",       1, 1, K_ST, 3, 'h4c, 0, 'hf, 0);
        add_row("ld_c0",       0, 0, K_LD, 0, 'h40, 0, 0, 0);
        add_row("ld_c1",       1, 0, K_LD, 1, 'h44, 0, 0, 0);
        add_row("ld_c2",       1, 0, K_LD, 2, 'h48, 0, 0, 0);
        add_row("ld_c3",       1, 0, K_LD, 3, 'h4c, 0, 0, 0);
        add_row("st_80",       0, 1, K_ST, 2, 'h80, 0, 'hf, 0);
        add_row("lr_c2",       0, 0, K_LR, 2, 'h80, 0, 0, 0);
        add_row("sc_c2",       0, 1, K_SC, 2, 'h80, 0, 'hf, 0);
        add_row("ld_after_sc", 0, 0, K_LD, 3, 'h80, 0, 0, 0);
        add_row("st_90",       0, 1, K_ST, 3, 'h90, 0, 'hf, 0);
        add_row("lr_c0",       0, 0, K_LR, 0, 'h90, 0, 0, 0);
        add_row("st_c1_90",    0, 1, K_ST, 1, 'h90, 0, 'hf, 0);
        add_row("sc_lost",     0, 1, K_SC, 0, 'h90, 0, 'hf, 1);
        add_row("ld_c1_value", 0, 0, K_LD, 0, 'h90, 0, 0, 0);
        add_row("sc_no_rsv",   0, 1, K_SC, 3, 'ha0, 0, 'hf, 1);
        add_row("lr_c1",       0, 0, K_LR, 1, 'h80, 0, 0, 0);
        add_row("sc_once",     0, 1, K_SC, 1, 'h80, 0, 'hf, 0);
        add_row("sc_twice",    0, 1, K_SC, 1, 'h80, 0, 'hf, 1);
    endtask

    task automatic drive_row(input int n);
        row_t r;
        r = tab[n];
        chk.note(r.core, tname[n], r.exp_fail);
        req[r.core].valid = 1'b1;
        req[r.core].we    = (r.kind == K_ST || r.kind == K_SC);
        req[r.core].lr    = (r.kind == K_LR);
        req[r.core].sc    = (r.kind == K_SC);
        req[r.core].addr  = r.addr;
        req[r.core].wdata = r.rnd ? $random(seed) : r.wdata;
        req[r.core].wstrb = req[r.core].we ? r.wstrb : '0;
    endtask

    task automatic wait_idle(input logic [NCORES-1:0] mask, input string what);
        int cnt;
        cnt = 0;
        @(posedge clk);
        #1;
        while ((busy & mask) != '0 && cnt < TIMEOUT) begin
            @(posedge clk);
            #1;
            cnt++;
        end
        if ((busy & mask) != '0) begin
            $display("timeout: busy stayed high before issuing %s", what);
            timed_out = 1'b1;
        end
    endtask

    task automatic wait_rsp(input logic [NCORES-1:0] mask, input string what);
        int                cnt;
        logic [NCORES-1:0] seen;
        cnt  = 0;
        seen = '0;
        while (seen != mask && cnt < TIMEOUT) begin
            @(posedge clk);
            #1;
            seen = seen | (rsp_valid & mask);
            cnt++;
        end
        if (seen != mask) begin
            $display("timeout: no response for %s (cores %b answered)", what, seen);
            timed_out = 1'b1;
        end
    endtask

    initial begin : run
        int                i;
        int                j;
        logic [NCORES-1:0] mask;
        rst = 1'b1;
        req = '0;
        load_table();
        repeat (3) @(posedge clk);
        #1 rst = 1'b0;
        repeat (4) @(posedge clk); // quiet window, idle outputs checked here
        i = 0;
        while (i < tab.size() && !timed_out) begin
            mask = '0;
            j    = i;
            while (j < tab.size() && (j == i || tab[j].same)) begin
                mask[tab[j].core] = 1'b1;
                j++;
            end
            wait_idle(mask, tname[i]);
            if (!timed_out) begin
                for (int n = i; n < j; n++) begin
                    drive_row(n);
                end
                @(posedge clk);
                #1 req = '0;
                wait_rsp(mask, tname[i]);
            end
            i = j;
        end
        @(posedge clk); // let the checker log the last response
        #1;
        $display("tests passed %0d, failed %0d", chk.n_pass, chk.n_fail);
        if (!timed_out && chk.n_fail == 0) begin
            $display("ALL CHECKS PASSED");
        end else begin
            $display("CHECKS FAILED");
        end
        $finish;
    end

endmodule

// File: all.f
rtl/dbus_pkg.sv
rtl/dbus_req_slots.sv
rtl/dbus_rr_arbiter.sv
rtl/dbus_lane_ctrl.sv
rtl/dbus_reservation.sv
rtl/dbus_dmem.sv
rtl/dbus_top.sv
bench/dbus_checker.sv
bench/tb_dbus.sv

// File: Bender.yml
package:
  name: dbus

sources:
  - rtl/dbus_pkg.sv
  - rtl/dbus_req_slots.sv
  - rtl/dbus_rr_arbiter.sv
  - rtl/dbus_lane_ctrl.sv
  - rtl/dbus_reservation.sv
  - rtl/dbus_dmem.sv
  - rtl/dbus_top.sv
  - target: simulation
    files:
      - bench/dbus_checker.sv
      - bench/tb_dbus.sv
